// File: rtl/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// data and address width
`define RV_XLEN 32

// architectural register count
`define RV_NREGS 32

// bits needed to index a register
`define RV_REG_AW 5

// first fetch address
`define RV_RESET_PC 32'h8000_0000

`endif

// File: rtl/rv_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_REG_AW-1:0] reg_idx_t;
  typedef logic [`RV_XLEN/8-1:0] strb_t;
  typedef logic [2:0]            funct3_t; // [2] unsigned load, [1:0] size

  typedef enum logic [6:0] {
    opc_op_imm = 7'b001_0011,
    opc_auipc  = 7'b001_0111,
    opc_lui    = 7'b011_0111,
    opc_jal    = 7'b110_1111,
    opc_jalr   = 7'b110_0111,
    opc_load   = 7'b000_0011,
    opc_store  = 7'b010_0011
  } opcode_e;

  typedef enum logic [2:0] {
    cls_alu, cls_upper_pc, cls_upper_zero, cls_jump_pc,
    cls_jump_reg, cls_load, cls_store, cls_illegal
  } op_class_e;

  // same 32 bits, four field layouts
  typedef union packed {
    struct packed {
      logic [11:0] imm;
      reg_idx_t    rs1;
      funct3_t     funct3;
      reg_idx_t    rd;
      opcode_e     opcode;
    } i_fmt;
    struct packed {
      logic [6:0] imm_hi;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      funct3_t    funct3;
      logic [4:0] imm_lo;
      opcode_e    opcode;
    } s_fmt;
    struct packed {
      logic [19:0] imm;
      reg_idx_t    rd;
      opcode_e     opcode;
    } u_fmt;
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      reg_idx_t   rd;
      opcode_e    opcode;
    } j_fmt;
  } inst_u;

endpackage

`default_nettype wire

// File: rtl/core_ifs.sv
`timescale 1ns/10ps
`default_nettype none

// decoded fields of the current instruction
interface decode_if;
  import rv_pkg::*;

  op_class_e op_class;
  word_t     imm;
  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  rd;
  funct3_t   funct3;
  logic      reg_wen;

  modport producer (output op_class, imm, rs1, rs2, rd, funct3, reg_wen);
  modport consumer (input op_class, imm, rs1, rs2, rd, funct3, reg_wen);
endinterface

// execute <-> load/store unit
interface mem_if;
  import rv_pkg::*;

  word_t addr;       // byte address from the adder
  word_t store_data; // unaligned rs2 value
  word_t load_data;  // extended load result
  logic  done;       // transfer completes this cycle

  modport requester (
    output addr, store_data,
    input  load_data, done
  );
  modport responder (
    input  addr, store_data,
    output load_data, done
  );
endinterface

`default_nettype wire

// File: rtl/inst_decode.sv
`timescale 1ns/10ps
`default_nettype none

module inst_decode (
  input wire rv_pkg::word_t inst,
  decode_if.producer        dec
);
  import rv_pkg::*;

  inst_u iw;
  word_t imm_i;
  word_t imm_s;
  word_t imm_u;
  word_t imm_j;

  assign iw = inst;

  // register indices sit in the same place for every format
  assign dec.rs1    = iw.i_fmt.rs1;
  assign dec.rs2    = iw.s_fmt.rs2;
  assign dec.rd     = iw.j_fmt.rd;
  assign dec.funct3 = iw.i_fmt.funct3;

  assign imm_i = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
  assign imm_s = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
  assign imm_u = {iw.u_fmt.imm, 12'h000}; // already in the upper bits
  assign imm_j = {{11{iw.j_fmt.imm20}}, iw.j_fmt.imm20, iw.j_fmt.imm19_12,
                  iw.j_fmt.imm11, iw.j_fmt.imm10_1, 1'b0};

  always_comb begin
    case (iw.u_fmt.opcode)
      opc_op_imm: dec.op_class = cls_alu; // every funct3 handled as addi
      opc_auipc:  dec.op_class = cls_upper_pc;
      opc_lui:    dec.op_class = cls_upper_zero;
      opc_jal:    dec.op_class = cls_jump_pc;
      opc_jalr:   dec.op_class = cls_jump_reg;
      opc_load:   dec.op_class = cls_load;
      opc_store:  dec.op_class = cls_store;
      default:    dec.op_class = cls_illegal;
    endcase
  end

  always_comb begin
    case (dec.op_class)
      cls_alu, cls_jump_reg, cls_load: dec.imm = imm_i;
      cls_store:                       dec.imm = imm_s;
      cls_upper_pc, cls_upper_zero:    dec.imm = imm_u;
      cls_jump_pc:                     dec.imm = imm_j;
      default:                         dec.imm = '0;
    endcase
  end

  // everything but store and unknown opcodes writes rd
  always_comb begin
    case (dec.op_class)
      cls_store, cls_illegal: dec.reg_wen = 1'b0;
      default:                dec.reg_wen = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module reg_file (
  input  wire                clk,
  input  wire                arst_n,
  decode_if.consumer         dec,
  input  wire                retire,
  input  wire rv_pkg::word_t wdata,
  output rv_pkg::word_t      rs1data,
  output rv_pkg::word_t      rs2data
);
  import rv_pkg::*;

  word_t regs [`RV_NREGS];
  logic  wr_en;

  // x0 never takes a write
  assign wr_en = retire && dec.reg_wen && (dec.rd != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[dec.rd] <= wdata;
    end
  end

  assign rs1data = regs[dec.rs1];
  assign rs2data = regs[dec.rs2];

  // reading x0 through either port gives zero
  x0_reads_zero: assert property (
    @(posedge clk) disable iff (!arst_n)
    ((dec.rs1 == '0) |-> (rs1data == '0)) and ((dec.rs2 == '0) |-> (rs2data == '0))
  );

endmodule

`default_nettype wire

// File: rtl/pc_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module pc_unit (
  input  wire                clk,
  input  wire                arst_n,
  decode_if.consumer         dec,
  input  wire                retire,
  input  wire rv_pkg::word_t target,
  output rv_pkg::word_t      pc,
  output rv_pkg::word_t      pc_plus4
);
  import rv_pkg::*;

  word_t pc_next;

  assign pc_plus4 = pc + 32'd4;

  always_comb begin
    pc_next = pc_plus4;
    if (dec.op_class == cls_jump_pc || dec.op_class == cls_jump_reg) begin
      pc_next = target;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RV_RESET_PC;
    end else if (retire) begin // hold while a transfer is pending
      pc <= pc_next;
    end
  end

  // misaligned jump target is a software fault
  pc_aligned: assert property (@(posedge clk) disable iff (!arst_n) retire |=> (pc[1:0] == 2'b00));

endmodule

`default_nettype wire

// File: rtl/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
  decode_if.consumer         dec,
  input  wire rv_pkg::word_t pc,
  input  wire rv_pkg::word_t pc_plus4,
  input  wire rv_pkg::word_t rs1data,
  input  wire rv_pkg::word_t rs2data,
  mem_if.requester           mem,
  output rv_pkg::word_t      wdata,
  output rv_pkg::word_t      target,
  output logic               retire
);
  import rv_pkg::*;

  word_t op_a;
  word_t sum;

  always_comb begin
    case (dec.op_class)
      cls_upper_pc, cls_jump_pc: op_a = pc;
      cls_upper_zero:            op_a = '0; // lui
      default:                   op_a = rs1data;
    endcase
  end

  // one adder for results, jump targets and addresses
  assign sum = op_a + dec.imm;

  assign mem.addr       = sum;
  assign mem.store_data = rs2data;

  // jalr drops bit 0
  assign target = (dec.op_class == cls_jump_reg) ? {sum[31:1], 1'b0} : sum;

  always_comb begin
    case (dec.op_class)
      cls_jump_pc, cls_jump_reg: wdata = pc_plus4; // link
      cls_load:                  wdata = mem.load_data;
      default:                   wdata = sum;
    endcase
  end

  assign retire = (dec.op_class == cls_load || dec.op_class == cls_store) ? mem.done : 1'b1;

endmodule

`default_nettype wire

// File: rtl/lsu.sv
`timescale 1ns/10ps
`default_nettype none

module lsu (
  input  wire                clk,
  input  wire                arst_n,
  decode_if.consumer         dec,
  mem_if.responder           mem,
  output rv_pkg::word_t      paddr,
  output logic               psel,
  output logic               penable,
  output logic               pwrite,
  output rv_pkg::word_t      pwdata,
  output rv_pkg::strb_t      pstrb,
  input  wire rv_pkg::word_t prdata,
  input  wire                pready
);
  import rv_pkg::*;

  localparam logic [1:0] st_idle   = 2'd0;
  localparam logic [1:0] st_setup  = 2'd1;
  localparam logic [1:0] st_access = 2'd2;

  logic [1:0] state_q;
  logic [1:0] state;
  logic       gap_q;   // bus idle cycle after a transfer
  logic       is_mem;
  logic       aligned;
  logic [1:0] offset;
  word_t      lane;

  assign is_mem = (dec.op_class == cls_load) || (dec.op_class == cls_store);
  assign offset = mem.addr[1:0];

  // setup is entered combinationally in the first cycle
  always_comb begin
    state = state_q;
    if (state_q == st_idle && is_mem && !gap_q) begin
      state = st_setup;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= st_idle;
      gap_q   <= 1'b0;
    end else begin
      gap_q <= 1'b0;
      case (state)
        st_setup: state_q <= st_access;
        st_access: begin
          if (pready) begin
            state_q <= st_idle;
            gap_q   <= 1'b1;
          end
        end
        default: state_q <= st_idle;
      endcase
    end
  end

  assign psel     = (state == st_setup) || (state == st_access);
  assign penable  = (state == st_access);
  assign pwrite   = (dec.op_class == cls_store);
  assign paddr    = {mem.addr[31:2], 2'b00};
  assign pwdata   = mem.store_data << {offset, 3'b000};
  assign mem.done = penable && pready;

  always_comb begin
    if (!pwrite) begin
      pstrb = '0; // reads carry no strobe
    end else begin
      case (dec.funct3[1:0])
        2'b00:   pstrb = 4'b0001 << offset;
        2'b01:   pstrb = 4'b0011 << offset;
        default: pstrb = 4'b1111;
      endcase
    end
  end

  // bring the addressed byte or half down to bit 0
  assign lane = prdata >> {offset, 3'b000};

  always_comb begin
    case (dec.funct3[1:0])
      2'b00:   mem.load_data = dec.funct3[2] ? {24'h0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
      2'b01:   mem.load_data = dec.funct3[2] ? {16'h0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
      default: mem.load_data = prdata;
    endcase
  end

  always_comb begin
    case (dec.funct3[1:0])
      2'b00:   aligned = 1'b1;
      2'b01:   aligned = (offset[0] == 1'b0);
      default: aligned = (offset == 2'b00);
    endcase
  end

  access_aligned: assert property (@(posedge clk) disable iff (!arst_n) psel |-> aligned);

  // address held through wait states
  paddr_stable: assert property (
    @(posedge clk) disable iff (!arst_n) (penable && !pready) |=> $stable(paddr)
  );

endmodule

`default_nettype wire

// File: rtl/rv_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_top (
  input  wire                clk,
  input  wire                arst_n,
  input  wire rv_pkg::word_t inst,
  output rv_pkg::word_t      pc,
  output rv_pkg::word_t      paddr,
  output logic               psel,
  output logic               penable,
  output logic               pwrite,
  output rv_pkg::word_t      pwdata,
  output rv_pkg::strb_t      pstrb,
  input  wire rv_pkg::word_t prdata,
  input  wire                pready
);
  import rv_pkg::*;

  word_t pc_plus4;
  word_t rs1data;
  word_t rs2data;
  word_t wdata;
  word_t target;
  logic  retire;

  decode_if dec_bus ();
  mem_if    mem_bus ();

  inst_decode inst_decode_inst (
    .inst (inst),
    .dec  (dec_bus.producer)
  );

  reg_file reg_file_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .dec     (dec_bus.consumer),
    .retire  (retire),
    .wdata   (wdata),
    .rs1data (rs1data),
    .rs2data (rs2data)
  );

  pc_unit pc_unit_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .dec      (dec_bus.consumer),
    .retire   (retire),
    .target   (target),
    .pc       (pc),
    .pc_plus4 (pc_plus4)
  );

  exec_unit exec_unit_inst (
    .dec      (dec_bus.consumer),
    .pc       (pc),
    .pc_plus4 (pc_plus4),
    .rs1data  (rs1data),
    .rs2data  (rs2data),
    .mem      (mem_bus.requester),
    .wdata    (wdata),
    .target   (target),
    .retire   (retire)
  );

  lsu lsu_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .dec     (dec_bus.consumer),
    .mem     (mem_bus.responder),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready)
  );

endmodule

`default_nettype wire

// File: verif/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "rv_params.svh"

module tb_rv_core;
  import rv_pkg::*;

  localparam int    N_ROWS   = 33;
  localparam int    N_STORES = 16;
  localparam word_t END_PC   = `RV_RESET_PC + 32'h84;
  localparam word_t NOP      = 32'h0000_0013; // addi x0, x0, 0

  logic  clk = 1'b0;
  logic  arst_n;
  word_t inst;
  word_t pc;
  word_t paddr;
  logic  psel;
  logic  penable;
  logic  pwrite;
  word_t pwdata;
  strb_t pstrb;
  word_t prdata;
  logic  pready;

  // program table, row index is (pc - reset pc) / 4
  word_t row_inst [N_ROWS];
  word_t row_next [N_ROWS];
  logic  row_wr   [N_ROWS];
  word_t row_addr [N_ROWS];
  word_t row_data [N_ROWS];
  strb_t row_strb [N_ROWS];
  int    n_rows;

  word_t       dmem [64]; // data memory at 0x1000
  word_t       exp_pc;
  word_t       lat_addr;  // address taken in the setup phase
  int          waits;
  int          cur_row;
  int          wr_count;
  logic        saw_setup;
  logic        gap_due;
  logic        xfer_done;
  logic        finished;

  always #50 clk = ~clk;

  rv_core_top rv_core_top_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .inst    (inst),
    .pc      (pc),
    .paddr   (paddr),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready)
  );

  function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, funct3_t f3, reg_idx_t rd,
                                  logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1, funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic word_t enc_u(logic [19:0] imm, reg_idx_t rd, logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  function automatic int row_of(word_t addr);
    word_t off;
    off = addr - `RV_RESET_PC;
    if (off >= 32'(4 * N_ROWS) || off[1:0] != 2'b00) begin
      return -1;
    end
    return int'(off >> 2);
  endfunction

  function automatic logic is_mem_row(int r);
    if (r < 0) begin
      return 1'b0;
    end
    return (row_inst[r][6:0] == 7'h03) || (row_inst[r][6:0] == 7'h23);
  endfunction

  function automatic word_t fetch_word(word_t addr);
    int r;
    r = row_of(addr);
    if (r < 0) begin
      return NOP;
    end
    return row_inst[r];
  endfunction

  function automatic word_t byte_mask(strb_t s);
    word_t m;
    for (int b = 0; b < 4; b++) begin
      m[8*b +: 8] = {8{s[b]}};
    end
    return m;
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_strb(string name, strb_t got, strb_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %s: got 0x%01h, expected 0x%01h", name, got, exp));
    end
  endtask

  task automatic add_row(word_t iw, word_t next_pc, logic wr, word_t addr, word_t data,
                         strb_t strb);
    row_inst[n_rows] = iw;
    row_next[n_rows] = next_pc;
    row_wr[n_rows]   = wr;
    row_addr[n_rows] = addr;
    row_data[n_rows] = data;
    row_strb[n_rows] = strb;
    n_rows++;
  endtask

  task automatic build_program();
    add_row(enc_u(20'h00001, 5'd1, 7'h37), 32'h8000_0004, 1'b0, '0, '0, '0); // x1 = 0x1000
    add_row(enc_i(12'hFFF, 5'd1, 3'd0, 5'd2, 7'h13), 32'h8000_0008, 1'b0, '0, '0, '0);
    add_row(enc_u(20'h12345, 5'd3, 7'h17), 32'h8000_000C, 1'b0, '0, '0, '0);
    add_row(enc_s(12'h000, 5'd2, 5'd1, 3'd2), 32'h8000_0010, 1'b1, 32'h1000, 32'h0000_0FFF, 4'hF);
    add_row(enc_s(12'h004, 5'd3, 5'd1, 3'd2), 32'h8000_0014, 1'b1, 32'h1004, 32'h9234_5008, 4'hF);
    add_row(enc_u(20'hFEDCB, 5'd4, 7'h37), 32'h8000_0018, 1'b0, '0, '0, '0);
    add_row(enc_i(12'h765, 5'd4, 3'd0, 5'd4, 7'h13), 32'h8000_001C, 1'b0, '0, '0, '0);
    add_row(enc_s(12'h008, 5'd4, 5'd1, 3'd2), 32'h8000_0020, 1'b1, 32'h1008, 32'hFEDC_B765, 4'hF);
    add_row(enc_j(21'd12, 5'd5), 32'h8000_002C, 1'b0, '0, '0, '0);
    add_row(NOP, 32'h8000_0028, 1'b0, '0, '0, '0); // jumped over
    add_row(NOP, 32'h8000_002C, 1'b0, '0, '0, '0);
    add_row(enc_s(12'h00C, 5'd5, 5'd1, 3'd2), 32'h8000_0030, 1'b1, 32'h100C, 32'h8000_0024, 4'hF);
    add_row(enc_u(20'h00000, 5'd6, 7'h17), 32'h8000_0034, 1'b0, '0, '0, '0);
    add_row(enc_i(12'h011, 5'd6, 3'd0, 5'd7, 7'h67), 32'h8000_0040, 1'b0, '0, '0, '0); // bit 0 off
    add_row(NOP, 32'h8000_003C, 1'b0, '0, '0, '0);
    add_row(NOP, 32'h8000_0040, 1'b0, '0, '0, '0);
    add_row(enc_s(12'h010, 5'd7, 5'd1, 3'd2), 32'h8000_0044, 1'b1, 32'h1010, 32'h8000_0038, 4'hF);
    add_row(enc_s(12'h020, 5'd4, 5'd1, 3'd0), 32'h8000_0048, 1'b1, 32'h1020, 32'h0000_0065, 4'h1);
    add_row(enc_s(12'h021, 5'd4, 5'd1, 3'd0), 32'h8000_004C, 1'b1, 32'h1020, 32'h0000_6500, 4'h2);
    add_row(enc_s(12'h022, 5'd4, 5'd1, 3'd0), 32'h8000_0050, 1'b1, 32'h1020, 32'h0065_0000, 4'h4);
    add_row(enc_s(12'h023, 5'd4, 5'd1, 3'd0), 32'h8000_0054, 1'b1, 32'h1020, 32'h6500_0000, 4'h8);
    add_row(enc_s(12'h024, 5'd4, 5'd1, 3'd1), 32'h8000_0058, 1'b1, 32'h1024, 32'h0000_B765, 4'h3);
    add_row(enc_s(12'h026, 5'd4, 5'd1, 3'd1), 32'h8000_005C, 1'b1, 32'h1024, 32'hB765_0000, 4'hC);
    add_row(enc_i(12'h043, 5'd1, 3'd0, 5'd8, 7'h03), 32'h8000_0060, 1'b0, '0, '0, '0); // lb
    add_row(enc_s(12'h030, 5'd8, 5'd1, 3'd2), 32'h8000_0064, 1'b1, 32'h1030, 32'hFFFF_FF8A, 4'hF);
    add_row(enc_i(12'h041, 5'd1, 3'd4, 5'd9, 7'h03), 32'h8000_0068, 1'b0, '0, '0, '0); // lbu
    add_row(enc_s(12'h034, 5'd9, 5'd1, 3'd2), 32'h8000_006C, 1'b1, 32'h1034, 32'h0000_00F0, 4'hF);
    add_row(enc_i(12'h042, 5'd1, 3'd1, 5'd10, 7'h03), 32'h8000_0070, 1'b0, '0, '0, '0); // lh
    add_row(enc_s(12'h038, 5'd10, 5'd1, 3'd2), 32'h8000_0074, 1'b1, 32'h1038, 32'hFFFF_8A9B, 4'hF);
    add_row(enc_i(12'h040, 5'd1, 3'd5, 5'd11, 7'h03), 32'h8000_0078, 1'b0, '0, '0, '0); // lhu
    add_row(enc_s(12'h03C, 5'd11, 5'd1, 3'd2), 32'h8000_007C, 1'b1, 32'h103C, 32'h0000_F0E1, 4'hF);
    add_row(enc_i(12'h040, 5'd1, 3'd2, 5'd12, 7'h03), 32'h8000_0080, 1'b0, '0, '0, '0); // lw
    add_row(enc_s(12'h02C, 5'd12, 5'd1, 3'd2), END_PC, 1'b1, 32'h102C, 32'h8A9B_F0E1, 4'hF);
  endtask

  task automatic fill_memory();
    word_t a;
    for (int i = 0; i < 64; i++) begin
      a = 32'h0000_1000 | (word_t'(i) << 2);
      dmem[i] = a ^ {a[15:0], a[31:16]} ^ 32'h3C3C_A5A5;
    end
    dmem[16] = 32'h8A9B_F0E1; // load source at 0x1040
  endtask

  task automatic complete_transfer();
    saw_setup = 1'b0;
    gap_due   = 1'b1;
    if (pwrite) begin
      if (!row_wr[cur_row]) begin
        fail_run($sformatf("unexpected write on the bus for pc 0x%08h", pc));
      end
      check_word("paddr", paddr, row_addr[cur_row]);
      check_strb("pstrb", pstrb, row_strb[cur_row]);
      check_word("pwdata", pwdata & byte_mask(pstrb), row_data[cur_row] & byte_mask(pstrb));
      for (int b = 0; b < 4; b++) begin
        if (pstrb[b]) begin
          dmem[paddr[7:2]][8*b +: 8] = pwdata[8*b +: 8];
        end
      end
      wr_count++;
    end else if (row_wr[cur_row]) begin
      fail_run($sformatf("a read came out where a store was expected at pc 0x%08h", pc));
    end
  endtask

  // slave response and next instruction, both on the falling edge
  always @(negedge clk) begin
    if (arst_n && !finished) begin
      check_word("pc", pc, exp_pc);
      if (pc == END_PC) begin
        finished = 1'b1;
      end
    end
    inst = fetch_word(pc);
    if (penable && waits == 0) begin
      pready = 1'b1;
      prdata = dmem[lat_addr[7:2]];
    end else begin
      if (penable) begin
        waits--;
      end
      pready = 1'b0;
    end
  end

  always @(posedge clk) begin
    if (arst_n && !finished) begin
      cur_row   = row_of(pc);
      xfer_done = psel && penable && pready;
      if (cur_row < 0) begin
        fail_run($sformatf("pc left the program at 0x%08h", pc));
      end
      if (gap_due && psel) begin
        fail_run("psel stayed high in the cycle after a completed transfer");
      end
      gap_due = 1'b0;
      if (psel && !is_mem_row(cur_row)) begin
        fail_run($sformatf("bus request from a non-memory instruction at pc 0x%08h", pc));
      end
      if (psel && !penable) begin // setup phase
        saw_setup = 1'b1;
        lat_addr  = paddr;
        waits     = $urandom % 4;
        if (paddr[31:8] != 24'h00_0010) begin
          fail_run($sformatf("bus access outside the data memory at 0x%08h", paddr));
        end
      end
      if (psel && penable) begin
        if (!saw_setup) begin
          fail_run("access phase began without a setup cycle");
        end
        check_word("paddr", paddr, lat_addr);
      end
      if (xfer_done) begin
        complete_transfer();
      end
      // memory instructions hold pc until the transfer ends
      if (!is_mem_row(cur_row) || xfer_done) begin
        exp_pc = row_next[cur_row];
      end else begin
        exp_pc = pc;
      end
    end
  end

  initial begin
    void'($urandom(82));
    arst_n    = 1'b0;
    inst      = NOP;
    prdata    = '0;
    pready    = 1'b0;
    exp_pc    = `RV_RESET_PC;
    lat_addr  = '0;
    waits     = 0;
    wr_count  = 0;
    n_rows    = 0;
    saw_setup = 1'b0;
    gap_due   = 1'b0;
    finished  = 1'b0;
    build_program();
    fill_memory();
    repeat (8) @(posedge clk);
    @(negedge clk);
    check_word("pc", pc, `RV_RESET_PC);
    if (psel) begin
      fail_run("psel is high while the core is held in reset");
    end
    arst_n = 1'b1;
    wait (finished);
    if (wr_count != N_STORES) begin
      fail_run($sformatf("%0d stores reached the bus, %0d expected", wr_count, N_STORES));
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

  // generous bound, no row needs more than a handful of cycles
  initial begin
    repeat (8 + 8 * N_ROWS) @(posedge clk);
    fail_run("watchdog expired before the program finished, the core hung");
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+rtl
rtl/rv_pkg.sv
rtl/core_ifs.sv
rtl/inst_decode.sv
rtl/reg_file.sv
rtl/pc_unit.sv
rtl/exec_unit.sv
rtl/lsu.sv
rtl/rv_core_top.sv
verif/tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): project.f $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
